/* hdl/arm_decode_pkg.sv */
package arm_decode_pkg;

// ==========================================================
// Register numbering.
// ==========================================================

localparam int unsigned REG_IDX_W = 5;

localparam logic [REG_IDX_W-1:0] ARCH_LR      = 5'd14;
localparam logic [REG_IDX_W-1:0] ARCH_PC      = 5'd15;

// Reads as zero, writes are discarded.
localparam logic [REG_IDX_W-1:0] RAZ_REGISTER = 5'd16;

// Operand flag values.
localparam logic INDEX_EN = 1'b1;
localparam logic IMMED_EN = 1'b0;

// ==========================================================
// Encodings.
// ==========================================================

typedef enum logic [3:0] {
        EQ, NE, CS, CC, MI, PL, VS, VC,
        HI, LS, GE, LT, GT, LE, AL, NV
} cond_t;

// Data-processing opcodes in encoded order.
typedef enum logic [3:0] {
        AND, EOR, SUB, RSB, ADD, ADC, SBC, RSC,
        TST, TEQ, CMP, CMN, ORR, MOV, BIC, MVN
} alu_op_t;

typedef enum logic [2:0] {
        LSL   = 3'd0,
        LSR   = 3'd1,
        ASR   = 3'd2,
        ROR   = 3'd3,
        RORI  = 3'd4,
        RRC   = 3'd5,
        ROR_1 = 3'd6
} shift_op_t;

// ==========================================================
// Decoded fields.
// ==========================================================

typedef struct packed {
        logic        is_index;
        logic [31:0] value;
} operand_t;

typedef struct packed {
        operand_t  source;
        operand_t  length;
        shift_op_t op;
} shift_field_t;

typedef struct packed {
        cond_t                 cond;
        alu_op_t               op;
        operand_t              source;
        logic [REG_IDX_W-1:0]  dest;
        logic                  flag_update;
} alu_field_t;

typedef struct packed {
        logic                  load;
        logic                  store;
        logic                  pre_index;
        logic                  byte_en;
        logic                  translate;
        logic [REG_IDX_W-1:0]  srcdest;
} mem_field_t;

typedef struct packed {
        alu_field_t   alu;
        shift_field_t shift;
        mem_field_t   mem;
        logic         und;
} decode_out_t;

// Idle output, a never-executing NOP.
localparam decode_out_t DECODE_DEFAULT = '{
        alu:   '{cond: NV, op: AND, source: '{IMMED_EN, 32'd0},
                 dest: RAZ_REGISTER, flag_update: 1'b0},
        shift: '{source: '{IMMED_EN, 32'd0}, length: '{IMMED_EN, 32'd0}, op: LSL},
        mem:   '{load: 1'b0, store: 1'b0, pre_index: 1'b0, byte_en: 1'b0,
                 translate: 1'b0, srcdest: RAZ_REGISTER},
        und:   1'b0
};

endpackage

/* hdl/shifter_operand_decoder.sv */
`timescale 1ns/1ps

module shifter_operand_decoder (
        input  logic [31:0]                  i_instruction,
        output arm_decode_pkg::shift_field_t o_dp_shift,
        output arm_decode_pkg::shift_field_t o_ls_shift
);

// ==========================================================
// Operand forms.
// ==========================================================

// Rotated 8-bit immediate. No rotation becomes LSL #0.
function automatic arm_decode_pkg::shift_field_t rot_imm(input logic [11:0] field);
        arm_decode_pkg::shift_field_t s;
        s.source = '{arm_decode_pkg::IMMED_EN, {24'd0, field[7:0]}};
        s.length = '{arm_decode_pkg::IMMED_EN, {27'd0, field[11:8], 1'b0}};
        s.op     = arm_decode_pkg::RORI;
        if (field[11:8] == 4'd0)
        begin
                s.op = arm_decode_pkg::LSL;
        end
        return s;
endfunction

// Rm shifted by a 5-bit amount held in the instruction.
function automatic arm_decode_pkg::shift_field_t iss(input logic [11:0] field);
        arm_decode_pkg::shift_field_t s;
        s.source = '{arm_decode_pkg::INDEX_EN, {28'd0, field[3:0]}};
        s.length = '{arm_decode_pkg::IMMED_EN, {27'd0, field[11:7]}};
        s.op     = arm_decode_pkg::shift_op_t'({1'b0, field[6:5]});

        // Zero amounts carry special meanings.
        case (field[6:5])
        2'b01, 2'b10:
        begin
                if (field[11:7] == 5'd0)
                begin
                        s.length.value = 32'd32;
                end
        end
        2'b11:
        begin
                // ROR #0 is rotate through carry.
                if (field[11:7] == 5'd0)
                begin
                        s.op = arm_decode_pkg::RRC;
                end
                else
                begin
                        s.op = arm_decode_pkg::ROR_1;
                end
        end
        default:
        begin
                s.op = arm_decode_pkg::LSL;
        end
        endcase
        return s;
endfunction

// Rm shifted by the amount in Rs.
function automatic arm_decode_pkg::shift_field_t rss(input logic [11:0] field);
        arm_decode_pkg::shift_field_t s;
        s.source = '{arm_decode_pkg::INDEX_EN, {28'd0, field[3:0]}};
        s.length = '{arm_decode_pkg::INDEX_EN, {28'd0, field[11:8]}};
        s.op     = arm_decode_pkg::shift_op_t'({1'b0, field[6:5]});
        return s;
endfunction

// ==========================================================
// Form selection.
// ==========================================================

always_comb
begin
        casez ({i_instruction[25], i_instruction[4]})
        2'b1?:   o_dp_shift = rot_imm(i_instruction[11:0]);
        2'b00:   o_dp_shift = iss(i_instruction[11:0]);
        default: o_dp_shift = rss(i_instruction[11:0]);
        endcase
end

always_comb
begin
        if (i_instruction[25])
        begin
                o_ls_shift = iss(i_instruction[11:0]);
        end
        else
        begin
                // Plain 12-bit offset.
                o_ls_shift.source = '{arm_decode_pkg::IMMED_EN, {20'd0, i_instruction[11:0]}};
                o_ls_shift.length = '{arm_decode_pkg::IMMED_EN, 32'd0};
                o_ls_shift.op     = arm_decode_pkg::LSL;
        end
end

endmodule

/* hdl/alu_mem_field_decoder.sv */
`timescale 1ns/1ps

module alu_mem_field_decoder (
        input  logic [31:0]                i_instruction,
        output arm_decode_pkg::alu_field_t o_dp_alu,
        output arm_decode_pkg::alu_field_t o_ls_alu,
        output arm_decode_pkg::mem_field_t o_ls_mem
);

logic [arm_decode_pkg::REG_IDX_W-1:0] rn;
logic [arm_decode_pkg::REG_IDX_W-1:0] rd;
logic                                 compare_op;
logic                                 base_update;

assign rn = {1'b0, i_instruction[19:16]};
assign rd = {1'b0, i_instruction[15:12]};

// TST, TEQ, CMP and CMN only set flags.
assign compare_op = (i_instruction[24:23] == 2'b10);

// Writeback, or post-index which always writes back.
assign base_update = i_instruction[21] || !i_instruction[24];

// ==========================================================
// Data processing.
// ==========================================================

always_comb
begin
        o_dp_alu.cond        = arm_decode_pkg::cond_t'(i_instruction[31:28]);
        o_dp_alu.op          = arm_decode_pkg::alu_op_t'(i_instruction[24:21]);
        o_dp_alu.source      = '{arm_decode_pkg::INDEX_EN, {27'd0, rn}};
        o_dp_alu.flag_update = i_instruction[20];
        o_dp_alu.dest        = compare_op ? arm_decode_pkg::RAZ_REGISTER : rd;
end

// ==========================================================
// Load/store.
// ==========================================================

always_comb
begin
        // Address is base plus or minus the offset.
        o_ls_alu.cond        = arm_decode_pkg::cond_t'(i_instruction[31:28]);
        o_ls_alu.op          = i_instruction[23] ? arm_decode_pkg::ADD : arm_decode_pkg::SUB;
        o_ls_alu.source      = '{arm_decode_pkg::INDEX_EN, {27'd0, rn}};
        o_ls_alu.flag_update = 1'b0;
        o_ls_alu.dest        = base_update ? rn : arm_decode_pkg::RAZ_REGISTER;
end

always_comb
begin
        o_ls_mem.load      = i_instruction[20];
        o_ls_mem.store     = !i_instruction[20];
        o_ls_mem.pre_index = i_instruction[24];
        o_ls_mem.byte_en   = i_instruction[22];
        o_ls_mem.srcdest   = rd;

        // Post-index with W set forces a user-mode access.
        o_ls_mem.translate = !i_instruction[24] && i_instruction[21];
end

endmodule

/* hdl/decode_select.sv */
`timescale 1ns/1ps

module decode_select (
        input  logic                         i_clk,
        input  logic                         i_rst_n,
        input  logic                         i_irq,
        input  logic                         i_fiq,
        input  logic                         i_abt,
        input  logic [31:0]                  i_instruction,
        input  logic                         i_instruction_valid,
        input  arm_decode_pkg::shift_field_t i_dp_shift,
        input  arm_decode_pkg::shift_field_t i_ls_shift,
        input  arm_decode_pkg::alu_field_t   i_dp_alu,
        input  arm_decode_pkg::alu_field_t   i_ls_alu,
        input  arm_decode_pkg::mem_field_t   i_ls_mem,
        output arm_decode_pkg::decode_out_t  o_decoded
);

arm_decode_pkg::decode_out_t next_decoded;

logic exception;
logic dp_und;
logic ls_und;

assign exception = i_irq || i_fiq || i_abt;

// Multiply space, and compares without S.
assign dp_und = (!i_instruction[25] && i_instruction[7] && i_instruction[4]) ||
                (i_instruction[24:23] == 2'b10 && !i_instruction[20]);

// Register offset with bit 4 set is media space.
assign ls_und = i_instruction[25] && i_instruction[4];

// LR = PC - 4, shared by exception, undefined and SWI entry.
function automatic arm_decode_pkg::decode_out_t lr_form(input arm_decode_pkg::cond_t cond,
                                                        input logic und);
        arm_decode_pkg::decode_out_t d;
        d                   = arm_decode_pkg::DECODE_DEFAULT;
        d.alu.cond          = cond;
        d.alu.op            = arm_decode_pkg::SUB;
        d.alu.source        = '{arm_decode_pkg::INDEX_EN, {27'd0, arm_decode_pkg::ARCH_PC}};
        d.alu.dest          = arm_decode_pkg::ARCH_LR;
        d.shift.source      = '{arm_decode_pkg::IMMED_EN, 32'd4};
        d.und               = und;
        return d;
endfunction

// ==========================================================
// Classification.
// ==========================================================

always_comb
begin
        next_decoded = arm_decode_pkg::DECODE_DEFAULT;

        if (exception)
        begin
                next_decoded = lr_form(arm_decode_pkg::AL, 1'b0);
        end
        else if (i_instruction_valid)
        begin
                if (i_instruction[31:28] == 4'b1111)
                begin
                        next_decoded = lr_form(arm_decode_pkg::AL, 1'b1);
                end
                else
                begin
                        casez (i_instruction[27:24])
                        4'b00??:
                        begin
                                if (dp_und)
                                begin
                                        next_decoded = lr_form(arm_decode_pkg::AL, 1'b1);
                                end
                                else
                                begin
                                        next_decoded.alu   = i_dp_alu;
                                        next_decoded.shift = i_dp_shift;
                                end
                        end
                        4'b01??:
                        begin
                                if (ls_und)
                                begin
                                        next_decoded = lr_form(arm_decode_pkg::AL, 1'b1);
                                end
                                else
                                begin
                                        next_decoded.alu   = i_ls_alu;
                                        next_decoded.shift = i_ls_shift;
                                        next_decoded.mem   = i_ls_mem;
                                end
                        end
                        4'b101?:
                        begin
                                // PC = PC + (offset << 2), link ignored.
                                next_decoded.alu.cond =
                                        arm_decode_pkg::cond_t'(i_instruction[31:28]);
                                next_decoded.alu.op     = arm_decode_pkg::ADD;
                                next_decoded.alu.source =
                                        '{arm_decode_pkg::INDEX_EN,
                                          {27'd0, arm_decode_pkg::ARCH_PC}};
                                next_decoded.alu.dest   = arm_decode_pkg::ARCH_PC;
                                next_decoded.shift.source =
                                        '{arm_decode_pkg::IMMED_EN,
                                          {{8{i_instruction[23]}}, i_instruction[23:0]}};
                                next_decoded.shift.length = '{arm_decode_pkg::IMMED_EN, 32'd2};
                        end
                        4'b1111:
                        begin
                                next_decoded = lr_form(
                                        arm_decode_pkg::cond_t'(i_instruction[31:28]), 1'b0);
                        end
                        default:
                        begin
                                next_decoded = lr_form(arm_decode_pkg::AL, 1'b1);
                        end
                        endcase
                end
        end
end

// ==========================================================
// Output register.
// ==========================================================

always_ff @(posedge i_clk)
begin
        if (!i_rst_n)
        begin
                o_decoded <= arm_decode_pkg::DECODE_DEFAULT;
        end
        else
        begin
                o_decoded <= next_decoded;
        end
end

endmodule

/* hdl/arm_decode_top.sv */
`timescale 1ns/1ps

module arm_decode_top (
        input  logic                        i_clk,
        input  logic                        i_rst_n,
        input  logic                        i_irq,
        input  logic                        i_fiq,
        input  logic                        i_abt,
        input  logic [31:0]                 i_instruction,
        input  logic                        i_instruction_valid,
        output arm_decode_pkg::decode_out_t o_decoded
);

arm_decode_pkg::shift_field_t dp_shift;
arm_decode_pkg::shift_field_t ls_shift;
arm_decode_pkg::alu_field_t   dp_alu;
arm_decode_pkg::alu_field_t   ls_alu;
arm_decode_pkg::mem_field_t   ls_mem;

// Both field decoders look at every instruction.
shifter_operand_decoder u_shifter_operand_decoder (
        .i_instruction (i_instruction),
        .o_dp_shift    (dp_shift),
        .o_ls_shift    (ls_shift)
);

alu_mem_field_decoder u_alu_mem_field_decoder (
        .i_instruction (i_instruction),
        .o_dp_alu      (dp_alu),
        .o_ls_alu      (ls_alu),
        .o_ls_mem      (ls_mem)
);

// Picks a form and registers it.
decode_select u_decode_select (
        .i_clk               (i_clk),
        .i_rst_n             (i_rst_n),
        .i_irq               (i_irq),
        .i_fiq               (i_fiq),
        .i_abt               (i_abt),
        .i_instruction       (i_instruction),
        .i_instruction_valid (i_instruction_valid),
        .i_dp_shift          (dp_shift),
        .i_ls_shift          (ls_shift),
        .i_dp_alu            (dp_alu),
        .i_ls_alu            (ls_alu),
        .i_ls_mem            (ls_mem),
        .o_decoded           (o_decoded)
);

endmodule

/* testbench/tb_vectors.svh */
// Each row gives a name, the irq, fiq and abt levels, the valid bit, the instruction
// and the expected decode.
// Expected values are assembled from the field helpers of the testbench.

task automatic fill_table();
        add_row("idle", 0, 0, 0, 0, 32'hE28214FF, idle_expect());

        // Data processing.
        add_row("add_rot_imm", 0, 0, 0, 1, 32'hE28214FF,
                dp_expect(arm_decode_pkg::ADD, 2, 1, 0,
                          shift_part(0, 32'hFF, 0, 8, arm_decode_pkg::RORI)));
        add_row("mov_rot_zero", 0, 0, 0, 1, 32'hE3A03055,
                dp_expect(arm_decode_pkg::MOV, 0, 3, 0,
                          shift_part(0, 32'h55, 0, 0, arm_decode_pkg::LSL)));
        add_row("cmps_raz_dest", 0, 0, 0, 1, 32'hE3540001,
                dp_expect(arm_decode_pkg::CMP, 4, arm_decode_pkg::RAZ_REGISTER, 1,
                          shift_part(0, 32'h1, 0, 0, arm_decode_pkg::LSL)));
        add_row("add_asr_reg", 0, 0, 0, 1, 32'hE0865857,
                dp_expect(arm_decode_pkg::ADD, 6, 5, 0,
                          shift_part(1, 32'd7, 1, 8, arm_decode_pkg::ASR)));

        // Immediate shift amounts of zero and a plain rotate.
        add_row("lsr_zero", 0, 0, 0, 1, 32'hE1A01022,
                dp_expect(arm_decode_pkg::MOV, 0, 1, 0,
                          shift_part(1, 32'd2, 0, 32, arm_decode_pkg::LSR)));
        add_row("ror_zero_rrc", 0, 0, 0, 1, 32'hE1A01062,
                dp_expect(arm_decode_pkg::MOV, 0, 1, 0,
                          shift_part(1, 32'd2, 0, 0, arm_decode_pkg::RRC)));
        add_row("ror_five", 0, 0, 0, 1, 32'hE1A012E2,
                dp_expect(arm_decode_pkg::MOV, 0, 1, 0,
                          shift_part(1, 32'd2, 0, 5, arm_decode_pkg::ROR_1)));

        // Load/store.
        add_row("ldr_pre_imm", 0, 0, 0, 1, 32'hE5921010,
                ls_expect(arm_decode_pkg::ADD, 2, arm_decode_pkg::RAZ_REGISTER,
                          shift_part(0, 32'h10, 0, 0, arm_decode_pkg::LSL),
                          mem_part(1, 0, 1, 0, 0, 1)));
        add_row("strbt_post", 0, 0, 0, 1, 32'hE4634008,
                ls_expect(arm_decode_pkg::SUB, 3, 3,
                          shift_part(0, 32'h8, 0, 0, arm_decode_pkg::LSL),
                          mem_part(0, 1, 0, 1, 1, 4)));
        add_row("ldr_reg_lsr0_wb", 0, 0, 0, 1, 32'hE7B65027,
                ls_expect(arm_decode_pkg::ADD, 6, 6,
                          shift_part(1, 32'd7, 0, 32, arm_decode_pkg::LSR),
                          mem_part(1, 0, 1, 0, 0, 5)));

        // Branch with link set and SWI.
        add_row("bl_backward", 0, 0, 0, 1, 32'hEBFFFFF0,
                dp_expect(arm_decode_pkg::ADD, arm_decode_pkg::ARCH_PC, arm_decode_pkg::ARCH_PC,
                          0, shift_part(0, 32'hFFFFFFF0, 0, 2, arm_decode_pkg::LSL)));
        add_row("swi_eq", 0, 0, 0, 1, 32'h0F000012, entry_expect(arm_decode_pkg::EQ, 0));

        // Exceptions win over any instruction.
        add_row("irq_over_add", 1, 0, 0, 1, 32'hE28214FF, entry_expect(arm_decode_pkg::AL, 0));
        add_row("fiq_idle", 0, 1, 0, 0, 32'h00000000, entry_expect(arm_decode_pkg::AL, 0));
        add_row("abt_idle", 0, 0, 1, 0, 32'hE5921010, entry_expect(arm_decode_pkg::AL, 0));

        // Undefined encodings.
        add_row("mul_und", 0, 0, 0, 1, 32'hE0010392, entry_expect(arm_decode_pkg::AL, 1));
        add_row("tst_no_s_und", 0, 0, 0, 1, 32'hE1000001, entry_expect(arm_decode_pkg::AL, 1));
        add_row("ls_media_und", 0, 0, 0, 1, 32'hE7921017, entry_expect(arm_decode_pkg::AL, 1));
        add_row("coproc_und", 0, 0, 0, 1, 32'hEE010F10, entry_expect(arm_decode_pkg::AL, 1));
        add_row("cond_nv_und", 0, 0, 0, 1, 32'hF28214FF, entry_expect(arm_decode_pkg::AL, 1));
        add_row("idle_after", 0, 0, 0, 0, 32'hEE010F10, idle_expect());
endtask

/* testbench/tb_arm_decode.sv */
`timescale 1ns/1ps

module tb_arm_decode;

localparam int CLK_PERIOD   = 10;
localparam int RESET_CYCLES = 5;

logic                        clk;
logic                        rst_n;
logic                        irq;
logic                        fiq;
logic                        abt;
logic [31:0]                 instruction;
logic                        instruction_valid;
arm_decode_pkg::decode_out_t decoded;

// One entry per table row. Control bits are {irq, fiq, abt, valid}.
string                       row_name[$];
logic [3:0]                  row_ctl[$];
logic [31:0]                 row_instr[$];
arm_decode_pkg::decode_out_t row_expect[$];

int                          pass_count;
int                          fail_count;
int                          row_idx;
bit                          table_ready;
bit                          reset_ok;
arm_decode_pkg::decode_out_t reset_seen;

arm_decode_top i_dut (
        .i_clk               (clk),
        .i_rst_n             (rst_n),
        .i_irq               (irq),
        .i_fiq               (fiq),
        .i_abt               (abt),
        .i_instruction       (instruction),
        .i_instruction_valid (instruction_valid),
        .o_decoded           (decoded)
);

always #(CLK_PERIOD / 2) clk = ~clk;

// ============================================================
// Expected value builders.
// ============================================================

function automatic arm_decode_pkg::shift_field_t shift_part(input logic src_idx,
        input logic [31:0] src_val, input logic len_idx, input logic [31:0] len_val,
        input arm_decode_pkg::shift_op_t op);
        arm_decode_pkg::shift_field_t s;
        s.source = '{src_idx, src_val};
        s.length = '{len_idx, len_val};
        s.op     = op;
        return s;
endfunction

function automatic arm_decode_pkg::mem_field_t mem_part(input logic load, input logic store,
        input logic pre, input logic byte_en, input logic translate, input logic [4:0] srcdest);
        arm_decode_pkg::mem_field_t m;
        m.load      = load;
        m.store     = store;
        m.pre_index = pre;
        m.byte_en   = byte_en;
        m.translate = translate;
        m.srcdest   = srcdest;
        return m;
endfunction

// Never-executing NOP with every register field on the discard register.
function automatic arm_decode_pkg::decode_out_t idle_expect();
        arm_decode_pkg::decode_out_t d;
        d.alu.cond        = arm_decode_pkg::NV;
        d.alu.op          = arm_decode_pkg::AND;
        d.alu.source      = '{arm_decode_pkg::IMMED_EN, 32'd0};
        d.alu.dest        = arm_decode_pkg::RAZ_REGISTER;
        d.alu.flag_update = 1'b0;
        d.shift           = shift_part(0, 32'd0, 0, 32'd0, arm_decode_pkg::LSL);
        d.mem             = mem_part(0, 0, 0, 0, 0, arm_decode_pkg::RAZ_REGISTER);
        d.und             = 1'b0;
        return d;
endfunction

// LR = PC - 4.
function automatic arm_decode_pkg::decode_out_t entry_expect(input arm_decode_pkg::cond_t cond,
                                                             input logic und);
        arm_decode_pkg::decode_out_t d;
        d              = idle_expect();
        d.alu.cond     = cond;
        d.alu.op       = arm_decode_pkg::SUB;
        d.alu.source   = '{arm_decode_pkg::INDEX_EN, {27'd0, arm_decode_pkg::ARCH_PC}};
        d.alu.dest     = arm_decode_pkg::ARCH_LR;
        d.shift.source = '{arm_decode_pkg::IMMED_EN, 32'd4};
        d.und          = und;
        return d;
endfunction

// Condition AL, register source, memory fields idle.
function automatic arm_decode_pkg::decode_out_t dp_expect(input arm_decode_pkg::alu_op_t op,
        input logic [4:0] rn, input logic [4:0] rd, input logic flag,
        input arm_decode_pkg::shift_field_t sh);
        arm_decode_pkg::decode_out_t d;
        d                 = idle_expect();
        d.alu.cond        = arm_decode_pkg::AL;
        d.alu.op          = op;
        d.alu.source      = '{arm_decode_pkg::INDEX_EN, {27'd0, rn}};
        d.alu.dest        = rd;
        d.alu.flag_update = flag;
        d.shift           = sh;
        return d;
endfunction

function automatic arm_decode_pkg::decode_out_t ls_expect(input arm_decode_pkg::alu_op_t op,
        input logic [4:0] rn, input logic [4:0] dest, input arm_decode_pkg::shift_field_t sh,
        input arm_decode_pkg::mem_field_t mem);
        arm_decode_pkg::decode_out_t d;
        d     = dp_expect(op, rn, dest, 1'b0, sh);
        d.mem = mem;
        return d;
endfunction

// ============================================================
// Table handling.
// ============================================================

task automatic add_row(input string name, input logic r_irq, input logic r_fiq,
        input logic r_abt, input logic r_valid, input logic [31:0] instr,
        input arm_decode_pkg::decode_out_t expected);
        row_name.push_back(name);
        row_ctl.push_back({r_irq, r_fiq, r_abt, r_valid});
        row_instr.push_back(instr);
        row_expect.push_back(expected);
endtask

task automatic apply_row(input int idx);
        irq               = row_ctl[idx][3];
        fiq               = row_ctl[idx][2];
        abt               = row_ctl[idx][1];
        instruction_valid = row_ctl[idx][0];
        instruction       = row_instr[idx];
endtask

task automatic check_row(input int idx);
        if (decoded !== row_expect[idx])
        begin
                fail_count++;
                $display("Fail %s expected %h actual %h", row_name[idx], row_expect[idx], decoded);
        end
        else
        begin
                pass_count++;
                $display("Pass %s", row_name[idx]);
        end
endtask

`include "tb_vectors.svh"

// ============================================================
// Main sequence.
// ============================================================

initial
begin
        clk               = 1'b0;
        rst_n             = 1'b0;
        irq               = 1'b0;
        fiq               = 1'b0;
        abt               = 1'b0;
        instruction       = 32'hE28214FF;
        instruction_valid = 1'b1;
        pass_count        = 0;
        fail_count        = 0;
        fill_table();
        table_ready = 1'b1;

        // A valid ADD is presented while reset holds the output at idle.
        reset_ok = 1'b1;
        repeat (RESET_CYCLES)
        begin
                @(posedge clk);
                #1;
                if (decoded !== idle_expect())
                begin
                        reset_ok   = 1'b0;
                        reset_seen = decoded;
                end
        end
        if (reset_ok)
        begin
                pass_count++;
                $display("Pass reset");
        end
        else
        begin
                fail_count++;
                $display("Fail reset expected %h actual %h", idle_expect(), reset_seen);
        end
        rst_n = 1'b1;

        // One row per cycle; each result is seen one edge later.
        for (row_idx = 0; row_idx <= row_name.size(); row_idx++)
        begin
                if (row_idx > 0)
                begin
                        @(posedge clk);
                        #1;
                        check_row(row_idx - 1);
                end
                if (row_idx < row_name.size())
                begin
                        apply_row(row_idx);
                end
        end

        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0)
        begin
                $display("No errors");
        end
        else
        begin
                $display("Errors found");
        end
        $finish;
end

initial
begin
        wait (table_ready);
        #((row_name.size() + RESET_CYCLES + 20) * CLK_PERIOD);
        $display("Timeout: the decoder run did not reach its end in time");
        $display("Errors found");
        $finish;
end

endmodule

/* filelist.f */
hdl/arm_decode_pkg.sv
hdl/shifter_operand_decoder.sv
hdl/alu_mem_field_decoder.sv
hdl/decode_select.sv
hdl/arm_decode_top.sv
testbench/tb_arm_decode.sv
+incdir+testbench
